// ==== common/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data and address width
`define LSU_XLEN        64

// Lanes and banks, one bank per lane (power of two)
`define LSU_LANES       2

// Address bits above the doubleword offset that pick the bank
`define LSU_BANK_BITS   1

// Doublewords held by each bank
`define LSU_BANK_WORDS  16

// Width of a lane number, never below one bit
`define LSU_LANE_ID_W   1

`endif

// ==== common/lsu_pkg.sv ====
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    // Access size as encoded on the request port
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } lsu_size_t;

    // One access as handed from the dispatcher to a lane
    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;     // Byte address
        logic [`LSU_XLEN-1:0] wdata;    // Store data, right aligned
        logic                 store;    // Write when set, else read
        lsu_size_t            size;
        logic                 sext;     // Sign extend load data
    } lsu_cmd_t;

    // Memory word, seen byte-wise by the bank and whole by the lane
    typedef union packed {
        logic [7:0][7:0]      bytes;
        logic [`LSU_XLEN-1:0] dword;
    } lsu_word_t;

endpackage

`default_nettype wire

// ==== common/lsu_ifs.sv ====
`default_nettype none

`include "lsu_consts.svh"

// Simple memory bus between a lane and its bank
interface mem_if;

    logic                 mem_req;  // Access request
    logic                 wen;      // Write enable
    logic [`LSU_XLEN-1:0] addr;     // Doubleword aligned
    lsu_pkg::lsu_word_t   wdata;
    logic [7:0]           strb;     // Byte strobes for writes
    logic                 gnt;      // Same cycle as mem_req
    lsu_pkg::lsu_word_t   rdata;    // Valid the cycle after the grant
    logic                 err;      // Bus error, same timing as rdata

    modport req (
        output mem_req, wen, addr, wdata, strb,
        input  gnt, rdata, err
    );

    modport rsp (
        input  mem_req, wen, addr, wdata, strb,
        output gnt, rdata, err
    );

endinterface

// Command and result path of one lane
interface lane_if;

    logic                 cmd_valid;
    lsu_pkg::lsu_cmd_t    cmd;
    logic                 cmd_busy;     // High from accept until result taken

    logic                 res_valid;
    logic [`LSU_XLEN-1:0] res_rdata;
    logic                 res_trap_addr;
    logic                 res_trap_bus;
    logic                 res_take;

    modport disp (output cmd_valid, cmd, input cmd_busy);

    modport lane (
        input  cmd_valid, cmd, res_take,
        output cmd_busy, res_valid, res_rdata, res_trap_addr, res_trap_bus
    );

    modport coll (
        input  res_valid, res_rdata, res_trap_addr, res_trap_bus,
        output res_take
    );

endinterface

`default_nettype wire

// ==== rtl/lsu_dispatch.sv ====
`default_nettype none

`include "lsu_consts.svh"

module lsu_dispatch (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [`LSU_XLEN-1:0]      req_addr,
    input  logic [`LSU_XLEN-1:0]      req_wdata,
    input  logic                      req_store,
    input  lsu_pkg::lsu_size_t        req_size,
    input  logic                      req_sext,

    lane_if.disp                      lanes [`LSU_LANES],

    output logic                      order_push,
    output logic [`LSU_LANE_ID_W-1:0] order_lane,
    input  logic                      order_full
);

    logic                      run_q;   // Low until the first cycle after reset
    logic [`LSU_LANE_ID_W-1:0] tgt;
    logic [`LSU_LANES-1:0]     busy;
    logic                      fire;
    lsu_pkg::lsu_cmd_t         cmd;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Bank interleave on the bits just above the doubleword offset
    assign tgt = req_addr[3 +: `LSU_BANK_BITS];

    assign req_ready  = run_q && !busy[tgt] && !order_full;
    assign fire       = req_valid && req_ready;

    assign order_push = fire;
    assign order_lane = tgt;

    always_comb begin
        cmd.addr  = req_addr;
        cmd.wdata = req_wdata;
        cmd.store = req_store;
        cmd.size  = req_size;
        cmd.sext  = req_sext;
    end

    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_disp
        assign busy[i]           = lanes[i].cmd_busy;
        assign lanes[i].cmd_valid = fire && (tgt == (`LSU_LANE_ID_W)'(i));
        assign lanes[i].cmd      = cmd; // Shared payload, only one lane sees valid

        a_no_cmd_to_busy: assert property (
            @(posedge g_clk) disable iff (!g_resetn)
            lanes[i].cmd_valid |-> !lanes[i].cmd_busy
        );
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_collect.sv ====
`default_nettype none

`include "lsu_consts.svh"

module lsu_collect (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    lane_if.coll                      lanes [`LSU_LANES],

    input  logic                      order_push,
    input  logic [`LSU_LANE_ID_W-1:0] order_lane,
    output logic                      order_full,

    output logic                      resp_valid,
    input  logic                      resp_ready,
    output logic [`LSU_XLEN-1:0]      resp_rdata,
    output logic                      resp_trap_addr,
    output logic                      resp_trap_bus
);

    // Order queue of lane numbers, one slot per lane
    logic [`LSU_LANE_ID_W-1:0] q_lane [`LSU_LANES];
    logic [`LSU_LANE_ID_W-1:0] wr_ptr;
    logic [`LSU_LANE_ID_W-1:0] rd_ptr;
    logic [`LSU_LANE_ID_W:0]   count;
    logic                      empty;
    logic                      pop;
    logic [`LSU_LANE_ID_W-1:0] head;

    logic [`LSU_LANES-1:0]     res_valid_v;
    logic [`LSU_XLEN-1:0]      res_rdata_v [`LSU_LANES];
    logic [`LSU_LANES-1:0]     res_taddr_v;
    logic [`LSU_LANES-1:0]     res_tbus_v;

    assign empty      = (count == '0);
    assign order_full = (count == (`LSU_LANE_ID_W+1)'(`LSU_LANES));
    assign head       = q_lane[rd_ptr];

    // Only the oldest lane may answer
    assign resp_valid     = !empty && res_valid_v[head];
    assign resp_rdata     = res_rdata_v[head];
    assign resp_trap_addr = res_taddr_v[head];
    assign resp_trap_bus  = res_tbus_v[head];
    assign pop            = resp_valid && resp_ready;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (order_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (order_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !order_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (order_push) begin
            q_lane[wr_ptr] <= order_lane;
        end
    end

    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_coll
        assign res_valid_v[i]    = lanes[i].res_valid;
        assign res_rdata_v[i]    = lanes[i].res_rdata;
        assign res_taddr_v[i]    = lanes[i].res_trap_addr;
        assign res_tbus_v[i]     = lanes[i].res_trap_bus;
        assign lanes[i].res_take = pop && (head == (`LSU_LANE_ID_W)'(i));
    end

    a_no_push_full: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        order_push |-> !order_full
    );

    // A lane result always has its issue entry, so a pop never finds the queue empty
    a_no_pop_empty: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (|res_valid_v) |-> !empty
    );

endmodule

`default_nettype wire

// ==== lsu_lane/lsu_data_bank.sv ====
`default_nettype none

`include "lsu_consts.svh"

module lsu_data_bank (
    input  logic g_clk,
    input  logic g_resetn,
    mem_if.rsp   mem
);

    localparam int IDX_W = $clog2(`LSU_BANK_WORDS);

    lsu_pkg::lsu_word_t                        mem_q [`LSU_BANK_WORDS];
    lsu_pkg::lsu_word_t                        rdata_q;
    logic                                      err_q;
    logic [`LSU_XLEN-4-`LSU_BANK_BITS:0]       idx;
    logic                                      in_range;
    logic [IDX_W-1:0]                          widx;

    // Word index sits above the doubleword offset and the bank select
    assign idx      = mem.addr[`LSU_XLEN-1:3+`LSU_BANK_BITS];
    assign in_range = (idx < `LSU_BANK_WORDS);
    assign widx     = idx[IDX_W-1:0];

    assign mem.gnt   = mem.mem_req;    // Always granted at once
    assign mem.rdata = rdata_q;
    assign mem.err   = err_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int w = 0; w < `LSU_BANK_WORDS; w++) begin
                mem_q[w] <= '0;
            end
            err_q <= 1'b0;
        end else if (mem.mem_req) begin
            err_q <= !in_range;
            if (in_range && mem.wen) begin
                for (int b = 0; b < 8; b++) begin
                    if (mem.strb[b]) begin
                        mem_q[widx].bytes[b] <= mem.wdata.bytes[b];
                    end
                end
            end
        end
    end

    // Old word comes back for stores too
    always_ff @(posedge g_clk) begin
        if (mem.mem_req) begin
            rdata_q <= in_range ? mem_q[widx] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_lane/lsu_lane.sv ====
`default_nettype none

`include "lsu_consts.svh"

module lsu_lane (
    input  logic g_clk,
    input  logic g_resetn,
    lane_if.lane lif,
    mem_if.req   mem
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_HOLD = 2'd3;

    logic [1:0]           state;
    lsu_pkg::lsu_cmd_t    cmd_q;
    logic [`LSU_XLEN-1:0] rdata_q;
    logic                 trap_addr_q;
    logic                 trap_bus_q;

    logic                 d_byte;
    logic                 d_half;
    logic                 d_word;
    logic                 d_double;
    logic                 addr_err;
    logic [5:0]           data_shift;
    logic [7:0]           strb_base;
    logic [`LSU_XLEN-1:0] rd_shifted;
    logic [`LSU_XLEN-1:0] rd_shaped;

    // Size decode
    assign d_byte   = (cmd_q.size == lsu_pkg::SIZE_BYTE);
    assign d_half   = (cmd_q.size == lsu_pkg::SIZE_HALF);
    assign d_word   = (cmd_q.size == lsu_pkg::SIZE_WORD);
    assign d_double = (cmd_q.size == lsu_pkg::SIZE_DOUBLE);

    assign addr_err = d_double && |cmd_q.addr[2:0] ||
                      d_word   && |cmd_q.addr[1:0] ||
                      d_half   &&  cmd_q.addr[0];

    assign data_shift = {cmd_q.addr[2:0], 3'b000};  // Byte offset in bits

    // Strobe pattern at offset zero, moved up by the byte offset
    assign strb_base = d_double ? 8'hff :
                       d_word   ? 8'h0f :
                       d_half   ? 8'h03 :
                                  8'h01;

    assign mem.mem_req = (state == ST_REQ) && !addr_err;   // Misaligned never hits the bus
    assign mem.wen     = cmd_q.store;
    assign mem.addr    = {cmd_q.addr[`LSU_XLEN-1:3], 3'b000};
    assign mem.wdata   = lsu_pkg::lsu_word_t'(cmd_q.wdata << data_shift);
    assign mem.strb    = strb_base << cmd_q.addr[2:0];

    assign rd_shifted = mem.rdata.dword >> data_shift;

    // Mask to size, then extend
    always_comb begin
        if (d_byte) begin
            rd_shaped = {{(`LSU_XLEN-8){cmd_q.sext && rd_shifted[7]}}, rd_shifted[7:0]};
        end else if (d_half) begin
            rd_shaped = {{(`LSU_XLEN-16){cmd_q.sext && rd_shifted[15]}}, rd_shifted[15:0]};
        end else if (d_word) begin
            rd_shaped = {{(`LSU_XLEN-32){cmd_q.sext && rd_shifted[31]}}, rd_shifted[31:0]};
        end else begin
            rd_shaped = rd_shifted;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (lif.cmd_valid) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (addr_err) begin
                        state <= ST_HOLD;   // Trap result ready one cycle early
                    end else if (mem.gnt) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: state <= ST_HOLD;
                default: begin
                    if (lif.res_take) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (state == ST_IDLE && lif.cmd_valid) begin
            cmd_q <= lif.cmd;
        end
        if (state == ST_REQ && addr_err) begin
            rdata_q     <= '0;
            trap_addr_q <= 1'b1;
            trap_bus_q  <= 1'b0;
        end
        if (state == ST_WAIT) begin
            rdata_q     <= rd_shaped;
            trap_addr_q <= 1'b0;
            trap_bus_q  <= mem.err;     // Bank range error
        end
    end

    assign lif.cmd_busy      = (state != ST_IDLE);
    assign lif.res_valid     = (state == ST_HOLD);
    assign lif.res_rdata     = rdata_q;
    assign lif.res_trap_addr = trap_addr_q;
    assign lif.res_trap_bus  = trap_bus_q;

    a_no_req_while_held: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        $rose(mem.mem_req) |-> !lif.res_valid
    );

endmodule

`default_nettype wire

// ==== rtl/lsu_cluster.sv ====
`default_nettype none

`include "lsu_consts.svh"

module lsu_cluster (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [`LSU_XLEN-1:0]      req_addr,
    input  logic [`LSU_XLEN-1:0]      req_wdata,
    input  logic                      req_store,
    input  lsu_pkg::lsu_size_t        req_size,
    input  logic                      req_sext,

    output logic                      resp_valid,
    input  logic                      resp_ready,
    output logic [`LSU_XLEN-1:0]      resp_rdata,
    output logic                      resp_trap_addr,
    output logic                      resp_trap_bus
);

    lane_if lanes [`LSU_LANES] ();
    mem_if  mems  [`LSU_LANES] ();

    // Issue order from dispatcher to collector
    logic                      order_push;
    logic [`LSU_LANE_ID_W-1:0] order_lane;
    logic                      order_full;

    lsu_dispatch dispatch_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_store  (req_store),
        .req_size   (req_size),
        .req_sext   (req_sext),
        .lanes      (lanes),
        .order_push (order_push),
        .order_lane (order_lane),
        .order_full (order_full)
    );

    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
        lsu_lane lane_inst (
            .g_clk    (g_clk),
            .g_resetn (g_resetn),
            .lif      (lanes[i]),
            .mem      (mems[i])
        );

        // One bank per lane, interleaved on doubleword address
        lsu_data_bank bank_inst (
            .g_clk    (g_clk),
            .g_resetn (g_resetn),
            .mem      (mems[i])
        );
    end

    lsu_collect collect_inst (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .lanes          (lanes),
        .order_push     (order_push),
        .order_lane     (order_lane),
        .order_full     (order_full),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp_rdata     (resp_rdata),
        .resp_trap_addr (resp_trap_addr),
        .resp_trap_bus  (resp_trap_bus)
    );

endmodule

`default_nettype wire

// ==== test/lsu_checker.sv ====
`default_nettype none

`include "lsu_consts.svh"

module lsu_checker (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 req_valid,
    input  logic                 req_ready,
    input  logic [`LSU_XLEN-1:0] req_addr,
    input  logic [`LSU_XLEN-1:0] req_wdata,
    input  logic                 req_store,
    input  lsu_pkg::lsu_size_t   req_size,
    input  logic                 req_sext,
    input  logic                 resp_valid,
    input  logic                 resp_ready,
    input  logic [`LSU_XLEN-1:0] resp_rdata,
    input  logic                 resp_trap_addr,
    input  logic                 resp_trap_bus,
    output int                   err_count,
    output int                   req_count,
    output int                   resp_count,
    output int                   pending
);

    localparam int MODEL_WORDS = `LSU_LANES * `LSU_BANK_WORDS;
    localparam int MODEL_AW    = $clog2(MODEL_WORDS);

    typedef struct packed {
        logic [`LSU_XLEN-1:0] rdata;
        logic                 check_data;   // Aligned in-range loads only
        logic                 trap_addr;
        logic                 trap_bus;
    } expect_t;

    // All banks side by side, indexed by doubleword address
    logic [`LSU_XLEN-1:0] model [MODEL_WORDS] = '{default: '0};
    expect_t              exp_q [$];
    int                   n_err  = 0;
    int                   n_req  = 0;
    int                   n_resp = 0;
    int                   n_pend = 0;

    assign err_count  = n_err;
    assign req_count  = n_req;
    assign resp_count = n_resp;
    assign pending    = n_pend;

    // Apply one request to the model in issue order
    function automatic expect_t model_access(
        input logic [`LSU_XLEN-1:0] addr,
        input logic [`LSU_XLEN-1:0] wdata,
        input logic                 store,
        input lsu_pkg::lsu_size_t   size,
        input logic                 sext
    );
        expect_t              e;
        int                   nbytes;
        int                   off;
        int                   idx;
        logic [`LSU_XLEN-1:0] val;
        nbytes = 1 << int'(size);
        off    = int'(addr[2:0]);
        idx    = int'(addr[3 +: MODEL_AW]);
        e      = '0;
        if (off % nbytes != 0) begin
            e.trap_addr = 1'b1;
        // Bank word index beyond depth, same as doubleword beyond all banks
        end else if (addr[`LSU_XLEN-1:3] >= (`LSU_XLEN-3)'(MODEL_WORDS)) begin
            e.trap_bus = 1'b1;
        end else if (store) begin
            for (int k = 0; k < nbytes; k++) begin
                model[idx][8*(off+k) +: 8] = wdata[8*k +: 8];
            end
        end else begin
            val = '0;
            for (int k = 0; k < nbytes; k++) begin
                val[8*k +: 8] = model[idx][8*(off+k) +: 8];
            end
            if (sext && nbytes < 8 && val[8*nbytes-1]) begin
                for (int k = nbytes; k < 8; k++) begin
                    val[8*k +: 8] = 8'hff;  // Fill upper bytes with the sign
                end
            end
            e.rdata      = val;
            e.check_data = 1'b1;
        end
        return e;
    endfunction

    task automatic compare_response(input expect_t e, input int num);
        if (resp_trap_addr !== e.trap_addr) begin
            $display("FAILED @%0t: response %0d trap_addr %0b, expected %0b",
                     $time, num, resp_trap_addr, e.trap_addr);
            n_err++;
        end
        if (resp_trap_bus !== e.trap_bus) begin
            $display("FAILED @%0t: response %0d trap_bus %0b, expected %0b",
                     $time, num, resp_trap_bus, e.trap_bus);
            n_err++;
        end
        if (e.check_data && resp_rdata !== e.rdata) begin
            $display("FAILED @%0t: response %0d rdata %h, expected %h",
                     $time, num, resp_rdata, e.rdata);
            n_err++;
        end
    endtask

    // Falling edge, where all ports have settled
    always @(negedge g_clk) begin
        if (g_resetn) begin
            if (resp_valid && resp_ready) begin
                n_resp++;
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t: a response arrived with no request outstanding",
                             $time);
                    n_err++;
                end else begin
                    compare_response(exp_q.pop_front(), n_resp);
                end
            end
            if (req_valid && req_ready) begin
                n_req++;
                exp_q.push_back(model_access(req_addr, req_wdata, req_store,
                                             req_size, req_sext));
            end
            n_pend = exp_q.size();
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_lsu_cluster.sv ====
`default_nettype none

`include "lsu_consts.svh"

module tb_lsu_cluster;

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DLY     = 10;
    localparam int NUM_REQS      = 2000;
    localparam int WATCHDOG_TIME = NUM_REQS * 10 * CLK_PERIOD;
    localparam int SPAN          = `LSU_LANES * `LSU_BANK_WORDS * 8;   // Bytes in range

    logic                 g_clk;
    logic                 g_resetn;
    logic                 req_valid;
    logic                 req_ready;
    logic [`LSU_XLEN-1:0] req_addr;
    logic [`LSU_XLEN-1:0] req_wdata;
    logic                 req_store;
    lsu_pkg::lsu_size_t   req_size;
    logic                 req_sext;
    logic                 resp_valid;
    logic                 resp_ready;
    logic [`LSU_XLEN-1:0] resp_rdata;
    logic                 resp_trap_addr;
    logic                 resp_trap_bus;
    int                   err_count;
    int                   req_count;
    int                   resp_count;
    int                   pending;

    lsu_cluster lsu_cluster_inst (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_store      (req_store),
        .req_size       (req_size),
        .req_sext       (req_sext),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp_rdata     (resp_rdata),
        .resp_trap_addr (resp_trap_addr),
        .resp_trap_bus  (resp_trap_bus)
    );

    lsu_checker checker_inst (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_store      (req_store),
        .req_size       (req_size),
        .req_sext       (req_sext),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp_rdata     (resp_rdata),
        .resp_trap_addr (resp_trap_addr),
        .resp_trap_bus  (resp_trap_bus),
        .err_count      (err_count),
        .req_count      (req_count),
        .resp_count     (resp_count),
        .pending        (pending)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD/2) g_clk = ~g_clk;
    end

    // Mostly in-range and aligned, some out of range or misaligned
    task automatic make_request();
        logic [`LSU_XLEN-1:0] addr;
        int                   pick;
        int                   nbytes;
        pick = $urandom_range(0, 99);
        if (pick < 90) begin
            addr = `LSU_XLEN'($urandom_range(0, SPAN - 1));
        end else if (pick < 97) begin
            addr = `LSU_XLEN'(SPAN + $urandom_range(0, SPAN - 1));
        end else begin
            addr = {$urandom, $urandom};    // Far out of range
        end
        req_size = lsu_pkg::lsu_size_t'(2'($urandom_range(0, 3)));
        nbytes   = 1 << int'(req_size);
        if ($urandom_range(0, 99) < 88) begin
            addr = addr & ~(`LSU_XLEN'(nbytes - 1));
        end
        req_addr  = addr;
        req_wdata = {$urandom, $urandom};
        req_store = 1'($urandom_range(0, 1));
        req_sext  = 1'($urandom_range(0, 1));
        req_valid = 1'b1;
    endtask

    initial begin : stimulus
        int   issued;
        int   accepted;
        int   end_errors;
        logic fired;
        void'($urandom(12));
        g_resetn   = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_store  = 1'b0;
        req_size   = lsu_pkg::SIZE_BYTE;
        req_sext   = 1'b0;
        resp_ready = 1'b0;
        repeat (5) @(posedge g_clk);
        #DRIVE_DLY;
        g_resetn = 1'b1;
        issued   = 0;
        accepted = 0;
        while (accepted < NUM_REQS) begin
            @(negedge g_clk);
            fired = req_valid && req_ready;     // Transfer at the coming edge
            @(posedge g_clk);
            #DRIVE_DLY;
            if (fired) begin
                accepted++;
                req_valid = 1'b0;
            end
            resp_ready = ($urandom_range(0, 3) != 0);
            if (!req_valid && issued < NUM_REQS && $urandom_range(0, 7) != 0) begin
                make_request();
                issued++;
            end
        end
        while (pending != 0) begin
            @(posedge g_clk);
            #DRIVE_DLY;
            resp_ready = ($urandom_range(0, 3) != 0);
        end
        resp_ready = 1'b1;
        repeat (5) @(posedge g_clk);            // Stray responses would show here
        end_errors = 0;
        if (resp_count != req_count) begin
            $display("Transfer count mismatch: %0d requests accepted, %0d responses",
                     req_count, resp_count);
            end_errors++;
        end
        $display("Checked %0d requests, %0d responses: %0d compare errors, %0d count errors",
                 req_count, resp_count, err_count, end_errors);
        if (err_count + end_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #WATCHDOG_TIME;
        $display("Timeout: run did not finish within %0d clock periods",
                 WATCHDOG_TIME / CLK_PERIOD);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+common
common/lsu_pkg.sv
common/lsu_ifs.sv
rtl/lsu_dispatch.sv
rtl/lsu_collect.sv
lsu_lane/lsu_data_bank.sv
lsu_lane/lsu_lane.sv
rtl/lsu_cluster.sv
test/lsu_checker.sv
test/tb_lsu_cluster.sv

// ==== run.sh ====
#!/bin/sh
# Build the LSU cluster testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_lsu_cluster \
    -o tb_lsu_cluster > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_lsu_cluster > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Test failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0
